//--- hdl/conv_cfg_pkg.sv
`default_nettype none

package conv_cfg_pkg;

    // Word width of pixels, weights and bias
    localparam int DATA_WIDTH = 8;

    // Partial sums and results
    // 20 bits hold any 3-tap result of 8-bit operands exactly
    localparam int ACC_WIDTH = 20;

    // Taps in the 1-D kernel, one MAC lane each
    localparam int KERNEL_W = 3;

    // Register stages inside each lane multiplier
    localparam int MUL_DELAY = 2;

    // Sideband bits carried with each beat
    localparam int USER_WIDTH = 2;

endpackage

`default_nettype wire

//--- hdl/conv_types_pkg.sv
`default_nettype none

package conv_types_pkg;

    // Signed input pixel
    typedef logic signed [conv_cfg_pkg::DATA_WIDTH-1:0] pixel_t;

    // Signed kernel weight, also used for the bias
    typedef logic signed [conv_cfg_pkg::DATA_WIDTH-1:0] weight_t;

    // Partial sum inside the chain and the final result
    typedef logic signed [conv_cfg_pkg::ACC_WIDTH-1:0] acc_t;

    // Per-beat sideband
    typedef logic [conv_cfg_pkg::USER_WIDTH-1:0] user_t;

    // Clamp negative results of this row to zero
    localparam int USER_RELU = 0;

    // First beat of a row, derived inside the unit from the previous last
    localparam int USER_FIRST = 1;

endpackage

`default_nettype wire

//--- hdl/conv_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface conv_stream_if #(
    parameter int KERNEL_W = conv_cfg_pkg::KERNEL_W
);

    logic                                    valid;
    logic                                    ready;
    conv_types_pkg::pixel_t                  pixel;
    conv_types_pkg::weight_t [KERNEL_W-1:0]  weights;
    conv_types_pkg::weight_t                 bias;
    logic                                    last;
    logic                                    relu;

    // Producer side
    modport src (output valid, pixel, weights, bias, last, relu, input ready);

    // Consumer side
    modport snk (input valid, pixel, weights, bias, last, relu, output ready);

endinterface

`default_nettype wire

//--- hdl/axis_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
    parameter int KERNEL_W = conv_cfg_pkg::KERNEL_W
) (
    input  logic                                   aclk,
    input  logic                                   rst_n,
    input  logic                                   s_valid,
    output logic                                   s_ready,
    input  conv_types_pkg::pixel_t                 s_pixel,
    input  conv_types_pkg::weight_t [KERNEL_W-1:0] s_weights,
    input  conv_types_pkg::weight_t                s_bias,
    input  logic                                   s_last,
    input  logic                                   s_relu,
    conv_stream_if.src                             m
);

    logic                                   main_valid;
    logic                                   skid_valid;
    logic                                   in_fire;
    logic                                   out_free;

    conv_types_pkg::pixel_t                 main_pixel;
    conv_types_pkg::weight_t [KERNEL_W-1:0] main_weights;
    conv_types_pkg::weight_t                main_bias;
    logic                                   main_last;
    logic                                   main_relu;

    conv_types_pkg::pixel_t                 skid_pixel;
    conv_types_pkg::weight_t [KERNEL_W-1:0] skid_weights;
    conv_types_pkg::weight_t                skid_bias;
    logic                                   skid_last;
    logic                                   skid_relu;

    // Ready comes straight from a flop
    assign s_ready  = !skid_valid;
    assign in_fire  = s_valid && s_ready;
    assign out_free = !main_valid || m.ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            main_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // Skid entry is older, so it goes out first
    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (skid_valid) begin
                main_pixel   <= skid_pixel;
                main_weights <= skid_weights;
                main_bias    <= skid_bias;
                main_last    <= skid_last;
                main_relu    <= skid_relu;
            end else if (in_fire) begin
                main_pixel   <= s_pixel;
                main_weights <= s_weights;
                main_bias    <= s_bias;
                main_last    <= s_last;
                main_relu    <= s_relu;
            end
        end else if (in_fire) begin
            skid_pixel   <= s_pixel;
            skid_weights <= s_weights;
            skid_bias    <= s_bias;
            skid_last    <= s_last;
            skid_relu    <= s_relu;
        end
    end

    assign m.valid   = main_valid;
    assign m.pixel   = main_pixel;
    assign m.weights = main_weights;
    assign m.bias    = main_bias;
    assign m.last    = main_last;
    assign m.relu    = main_relu;

    // Beat held intact while the unit stalls
    out_hold_a: assert property (@(posedge aclk) disable iff (!rst_n)
        m.valid && !m.ready |=> m.valid && $stable(m.pixel) && $stable(m.weights)
            && $stable(m.bias) && $stable(m.last) && $stable(m.relu));

endmodule

`default_nettype wire

//--- hdl/step_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module step_buffer #(
    parameter int KERNEL_W = conv_cfg_pkg::KERNEL_W
) (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    input  logic                                  en,
    input  logic                                  in_valid,
    input  conv_types_pkg::pixel_t                in_pixel,
    input  logic                                  in_first,
    output logic [KERNEL_W-1:0]                   out_valid,
    output conv_types_pkg::pixel_t [KERNEL_W-1:0] out_pixel,
    output logic [KERNEL_W-1:0]                   out_first
);

    // Tap 0 sees the live input
    assign out_valid[0] = in_valid;
    assign out_pixel[0] = in_pixel;
    assign out_first[0] = in_first;

    generate
        if (KERNEL_W > 1) begin : g_chain
            logic [KERNEL_W-1:1]                   vld_q;
            logic [KERNEL_W-1:1]                   first_q;
            conv_types_pkg::pixel_t [KERNEL_W-1:1] pix_q;

            always_ff @(posedge aclk) begin
                if (!rst_n) begin
                    vld_q   <= '0;
                    first_q <= '0;
                end else if (en) begin
                    vld_q[1]   <= in_valid;
                    first_q[1] <= in_first;
                    for (int j = 2; j < KERNEL_W; j++) begin
                        vld_q[j]   <= vld_q[j-1];
                        first_q[j] <= first_q[j-1];
                    end
                end
            end

            always_ff @(posedge aclk) begin
                if (en) begin
                    pix_q[1] <= in_pixel;
                    for (int j = 2; j < KERNEL_W; j++) begin
                        pix_q[j] <= pix_q[j-1];
                    end
                end
            end

            assign out_valid[KERNEL_W-1:1] = vld_q;
            assign out_pixel[KERNEL_W-1:1] = pix_q;
            assign out_first[KERNEL_W-1:1] = first_q;
        end
    endgenerate

endmodule

`default_nettype wire

//--- hdl/mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lane #(
    parameter int MUL_DELAY = conv_cfg_pkg::MUL_DELAY
) (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic                    pix_valid,
    input  conv_types_pkg::pixel_t  pixel,
    input  logic                    first,
    input  conv_types_pkg::weight_t weight_in,
    input  conv_types_pkg::acc_t    sum_in,
    output conv_types_pkg::acc_t    sum_out,
    output logic                    sum_valid
);

    conv_types_pkg::weight_t                 weight_q;
    conv_types_pkg::weight_t                 weight_use;
    conv_types_pkg::acc_t [MUL_DELAY-1:0]    prod_q;
    logic [MUL_DELAY-1:0]                    vld_q;
    logic                                    take_weight;

    assign take_weight = pix_valid && first;

    // Row opener multiplies with its own weight, later beats with the held one
    assign weight_use = take_weight ? weight_in : weight_q;

    always_ff @(posedge aclk) begin
        if (en && take_weight) begin
            weight_q <= weight_in;
        end
    end

    // Product sign-extends to the accumulator width before the multiply
    always_ff @(posedge aclk) begin
        if (en) begin
            prod_q[0] <= pixel * weight_use;
            for (int k = 1; k < MUL_DELAY; k++) begin
                prod_q[k] <= prod_q[k-1];
            end
            sum_out <= sum_in + prod_q[MUL_DELAY-1];
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            vld_q     <= '0;
            sum_valid <= 1'b0;
        end else if (en) begin
            vld_q[0] <= pix_valid;
            for (int k = 1; k < MUL_DELAY; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
            sum_valid <= vld_q[MUL_DELAY-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/conv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module conv_unit #(
    parameter int KERNEL_W  = conv_cfg_pkg::KERNEL_W,
    parameter int MUL_DELAY = conv_cfg_pkg::MUL_DELAY
) (
    input  logic                 aclk,
    input  logic                 rst_n,
    conv_stream_if.snk           s,
    output logic                 m_valid,
    input  logic                 m_ready,
    output conv_types_pkg::acc_t m_data,
    output logic                 m_last
);

    // Window tag travels as long as a pixel takes through the whole chain
    localparam int TAG_DELAY = KERNEL_W + MUL_DELAY;
    localparam int CNT_W     = $clog2(KERNEL_W + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(KERNEL_W - 1);

    logic                                   en;
    logic                                   in_fire;
    logic                                   first_pend;
    logic [CNT_W-1:0]                       row_cnt;
    logic                                   in_win;
    conv_types_pkg::weight_t                ctx_bias;
    logic                                   ctx_relu;
    conv_types_pkg::weight_t                row_bias;
    conv_types_pkg::user_t                  in_user;

    logic [KERNEL_W-1:0]                    tap_valid;
    conv_types_pkg::pixel_t [KERNEL_W-1:0]  tap_pixel;
    logic [KERNEL_W-1:0]                    tap_first;

    conv_types_pkg::weight_t [KERNEL_W-1:0] lane_weight;
    conv_types_pkg::acc_t [KERNEL_W-1:0]    lane_sum_in;
    conv_types_pkg::acc_t [KERNEL_W-1:0]    lane_sum;
    logic [KERNEL_W-1:0]                    lane_valid;

    conv_types_pkg::weight_t [MUL_DELAY-1:0] bias_q;
    logic [TAG_DELAY-1:0]                    tag_win_q;
    logic [TAG_DELAY-1:0]                    tag_last_q;
    conv_types_pkg::user_t [TAG_DELAY-1:0]   tag_user_q;
    conv_types_pkg::acc_t                    result;

    // Whole pipeline freezes while the output waits
    assign en      = !(m_valid && !m_ready);
    assign s.ready = en;
    assign in_fire = s.valid && en;

    // Row tracking, counter saturates once a full window is in
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            first_pend <= 1'b1;
            row_cnt    <= '0;
        end else if (in_fire) begin
            first_pend <= s.last;
            if (s.last) begin
                row_cnt <= '0;
            end else if (row_cnt != CNT_FULL) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Bias and relu of the current row
    always_ff @(posedge aclk) begin
        if (in_fire && first_pend) begin
            ctx_bias <= s.bias;
            ctx_relu <= s.relu;
        end
    end

    assign row_bias = first_pend ? s.bias : ctx_bias;
    assign in_win   = s.valid && (row_cnt == CNT_FULL);

    always_comb begin
        in_user                             = '0;
        in_user[conv_types_pkg::USER_FIRST] = first_pend;
        in_user[conv_types_pkg::USER_RELU]  = first_pend ? s.relu : ctx_relu;
    end

    step_buffer #(
        .KERNEL_W (KERNEL_W)
    ) u_step (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .en        (en),
        .in_valid  (s.valid),
        .in_pixel  (s.pixel),
        .in_first  (in_user[conv_types_pkg::USER_FIRST]),
        .out_valid (tap_valid),
        .out_pixel (tap_pixel),
        .out_first (tap_first)
    );

    // Bias meets lane 0 product after the multiplier stages
    always_ff @(posedge aclk) begin
        if (en) begin
            bias_q[0] <= row_bias;
            for (int k = 1; k < MUL_DELAY; k++) begin
                bias_q[k] <= bias_q[k-1];
            end
        end
    end

    generate
        for (genvar j = 0; j < KERNEL_W; j++) begin : g_lane
            if (j == 0) begin : g_head
                assign lane_weight[0] = s.weights[0];
                assign lane_sum_in[0] = conv_types_pkg::acc_t'(bias_q[MUL_DELAY-1]);
            end else begin : g_link
                conv_types_pkg::weight_t [j-1:0] w_q;
                conv_types_pkg::acc_t            sum_q;

                // Weight follows the pixel j taps down, sum gets one extra stage
                always_ff @(posedge aclk) begin
                    if (en) begin
                        w_q[0] <= s.weights[j];
                        for (int k = 1; k < j; k++) begin
                            w_q[k] <= w_q[k-1];
                        end
                        sum_q <= lane_sum[j-1];
                    end
                end

                assign lane_weight[j] = w_q[j-1];
                assign lane_sum_in[j] = sum_q;
            end

            mac_lane #(
                .MUL_DELAY (MUL_DELAY)
            ) u_lane (
                .aclk      (aclk),
                .rst_n     (rst_n),
                .en        (en),
                .pix_valid (tap_valid[j]),
                .pixel     (tap_pixel[j]),
                .first     (tap_first[j]),
                .weight_in (lane_weight[j]),
                .sum_in    (lane_sum_in[j]),
                .sum_out   (lane_sum[j]),
                .sum_valid (lane_valid[j])
            );
        end
    endgenerate

    // Window flags ride alongside the sums
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            tag_win_q <= '0;
        end else if (en) begin
            tag_win_q <= {tag_win_q[TAG_DELAY-2:0], in_win};
        end
    end

    always_ff @(posedge aclk) begin
        if (en) begin
            tag_last_q <= {tag_last_q[TAG_DELAY-2:0], s.last};
            tag_user_q <= {tag_user_q[TAG_DELAY-2:0], in_user};
        end
    end

    assign result  = lane_sum[KERNEL_W-1];
    assign m_valid = tag_win_q[TAG_DELAY-1] && lane_valid[KERNEL_W-1];
    assign m_last  = tag_last_q[TAG_DELAY-1];
    assign m_data  = (tag_user_q[TAG_DELAY-1][conv_types_pkg::USER_RELU] && result < 0)
                     ? '0 : result;

    // A row ending before a full window never yields output
    short_row_a: assert property (@(posedge aclk) disable iff (!rst_n)
        in_fire && s.last |-> row_cnt == CNT_FULL)
        else $warning("row ended after %0d beats, shorter than the kernel", row_cnt + 1);

    stall_hold_a: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last));

endmodule

`default_nettype wire

//--- hdl/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
    parameter int KERNEL_W  = conv_cfg_pkg::KERNEL_W,
    parameter int MUL_DELAY = conv_cfg_pkg::MUL_DELAY
) (
    input  logic                                   aclk,
    input  logic                                   rst_n,
    input  logic                                   s_valid,
    output logic                                   s_ready,
    input  conv_types_pkg::pixel_t                 s_pixel,
    input  conv_types_pkg::weight_t [KERNEL_W-1:0] s_weights,
    input  conv_types_pkg::weight_t                s_bias,
    input  logic                                   s_last,
    input  logic                                   s_relu,
    output logic                                   m_valid,
    input  logic                                   m_ready,
    output conv_types_pkg::acc_t                   m_data,
    output logic                                   m_last
);

    // Registered stream between the input slice and the conv chain
    conv_stream_if #(
        .KERNEL_W (KERNEL_W)
    ) slice_to_unit ();

    axis_reg_slice #(
        .KERNEL_W (KERNEL_W)
    ) u_slice (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_bias    (s_bias),
        .s_last    (s_last),
        .s_relu    (s_relu),
        .m         (slice_to_unit.src)
    );

    conv_unit #(
        .KERNEL_W  (KERNEL_W),
        .MUL_DELAY (MUL_DELAY)
    ) u_unit (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s       (slice_to_unit.snk),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data),
        .m_last  (m_last)
    );

endmodule

`default_nettype wire

//--- bench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    localparam int KERNEL_W   = conv_cfg_pkg::KERNEL_W;
    localparam int MUL_DELAY  = conv_cfg_pkg::MUL_DELAY;
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 16;
    // Slice register plus the systolic chain
    localparam int LATENCY    = KERNEL_W + MUL_DELAY + 1;

    logic                                   aclk;
    logic                                   rst_n;
    logic                                   s_valid;
    logic                                   s_ready;
    conv_types_pkg::pixel_t                 s_pixel;
    conv_types_pkg::weight_t [KERNEL_W-1:0] s_weights;
    conv_types_pkg::weight_t                s_bias;
    logic                                   s_last;
    logic                                   s_relu;
    logic                                   m_valid;
    logic                                   m_ready;
    conv_types_pkg::acc_t                   m_data;
    logic                                   m_last;

    // One pass worth of beats, plus the outputs they should give
    conv_types_pkg::pixel_t                 beat_pixel [$];
    conv_types_pkg::weight_t [KERNEL_W-1:0] beat_weights [$];
    conv_types_pkg::weight_t                beat_bias [$];
    logic                                   beat_last [$];
    logic                                   beat_relu [$];
    int                                     beat_pos [$];
    conv_types_pkg::acc_t                   exp_data [$];
    logic                                   exp_last [$];
    conv_types_pkg::acc_t                   model_data [$];
    logic                                   model_last [$];
    time                                    window_times [$];

    int data_errors;
    int last_errors;
    int flow_errors;
    int in_count;
    int out_count;
    int windows_seen;
    bit stall_mode;
    bit loaded;

    conv_top #(
        .KERNEL_W  (KERNEL_W),
        .MUL_DELAY (MUL_DELAY)
    ) dut_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_bias    (s_bias),
        .s_last    (s_last),
        .s_relu    (s_relu),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data),
        .m_last    (m_last)
    );

    always #(PERIOD / 2) aclk = ~aclk;

    task automatic check_data(input conv_types_pkg::acc_t got, input conv_types_pkg::acc_t want,
                              input string what);
        if (got !== want) begin
            data_errors++;
            $display("ERR %0t: %s data %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_last(input logic got, input logic want, input string what);
        if (got !== want) begin
            last_errors++;
            $display("ERR %0t: %s last %b, expected %b", $time, what, got, want);
        end
    endtask

    // y = bias + sum of w[j] * p[n-K+1+j], clamped at zero under relu
    task automatic model_row(input int pix [$], input conv_types_pkg::weight_t [KERNEL_W-1:0] w,
                             input conv_types_pkg::weight_t bias, input bit relu);
        int acc;
        for (int n = KERNEL_W - 1; n < pix.size(); n++) begin
            acc = int'(bias);
            for (int j = 0; j < KERNEL_W; j++) begin
                acc += int'(w[j]) * pix[n - KERNEL_W + 1 + j];
            end
            if (relu && acc < 0) begin
                acc = 0;
            end
            model_data.push_back(conv_types_pkg::acc_t'(acc));
            model_last.push_back(n == pix.size() - 1);
        end
    endtask

    task automatic load_patterns();
        int                                     fd;
        int                                     n;
        int                                     v;
        int                                     relu_v;
        int                                     bias_v;
        int                                     last_v;
        int                                     count;
        logic [63:0]                            tok;
        logic [8*256-1:0]                       rest;
        conv_types_pkg::weight_t [KERNEL_W-1:0] row_w;
        int                                     pix [$];

        fd = $fopen("bench/conv_patterns.txt", "r");
        if (fd == 0) begin
            flow_errors++;
            $display("Cannot open bench/conv_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                tok = '0;
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    continue;
                end
                if (tok == "#") begin
                    n = $fgets(rest, fd);
                end else if (tok == "row") begin
                    n = $fscanf(fd, "%d %d", relu_v, bias_v);
                    for (int j = 0; j < KERNEL_W; j++) begin
                        n = $fscanf(fd, "%d", v);
                        row_w[j] = conv_types_pkg::weight_t'(v);
                    end
                    n = $fscanf(fd, "%d", count);
                    pix.delete();
                    for (int k = 0; k < count; k++) begin
                        n = $fscanf(fd, "%d", v);
                        pix.push_back(int'(conv_types_pkg::pixel_t'(v)));
                        beat_pixel.push_back(conv_types_pkg::pixel_t'(v));
                        beat_weights.push_back(row_w);
                        beat_bias.push_back(conv_types_pkg::weight_t'(bias_v));
                        beat_last.push_back(k == count - 1);
                        beat_relu.push_back(relu_v != 0);
                        beat_pos.push_back(k);
                    end
                    model_row(pix, row_w, conv_types_pkg::weight_t'(bias_v), relu_v != 0);
                end else if (tok == "exp") begin
                    n = $fscanf(fd, "%d %d", v, last_v);
                    exp_data.push_back(conv_types_pkg::acc_t'(v));
                    exp_last.push_back(last_v != 0);
                end else begin
                    flow_errors++;
                    $display("Unknown entry in the pattern file");
                end
            end
            $fclose(fd);
        end

        // File results against the convolution rule
        if (model_data.size() != exp_data.size()) begin
            flow_errors++;
            $display("Pattern file lists %0d outputs but the rule gives %0d",
                     exp_data.size(), model_data.size());
        end else begin
            for (int i = 0; i < exp_data.size(); i++) begin
                check_data(exp_data[i], model_data[i], "pattern file");
                check_last(exp_last[i], model_last[i], "pattern file");
            end
        end
    endtask

    task automatic drive_pass(input bit gaps);
        for (int i = 0; i < beat_pixel.size(); i++) begin
            if (gaps && beat_pos[i] == 0) begin
                s_valid <= 1'b0;
                repeat ($urandom % 4) @(posedge aclk);
            end
            s_valid <= 1'b1;
            s_pixel <= beat_pixel[i];
            s_last  <= beat_last[i];
            if (beat_pos[i] == 0) begin
                s_weights <= beat_weights[i];
                s_bias    <= beat_bias[i];
                s_relu    <= beat_relu[i];
            end else begin
                // Row context must ignore these
                for (int j = 0; j < KERNEL_W; j++) begin
                    s_weights[j] <= conv_types_pkg::weight_t'($urandom);
                end
                s_bias <= conv_types_pkg::weight_t'($urandom);
                s_relu <= 1'($urandom);
            end
            @(posedge aclk);
            while (!s_ready) begin
                @(posedge aclk);
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic wait_outputs(input int target);
        while (out_count < target) begin
            @(posedge aclk);
        end
    endtask

    task automatic record_output();
        int  slot;
        time t0;
        if (windows_seen == 0) begin
            flow_errors++;
            $display("Output appeared at %0t before any full window was accepted", $time);
        end
        if (out_count >= 2 * exp_data.size()) begin
            flow_errors++;
            $display("Unexpected extra output %0d at %0t", m_data, $time);
        end else begin
            slot = out_count % exp_data.size();
            check_data(m_data, exp_data[slot], "output");
            check_last(m_last, exp_last[slot], "output");
            // Steady pass has a fixed latency
            if (out_count < exp_data.size()) begin
                if (window_times.size() == 0) begin
                    flow_errors++;
                    $display("Output at %0t has no accepted window behind it", $time);
                end else begin
                    t0 = window_times.pop_front();
                    if (($time - t0) != LATENCY * PERIOD) begin
                        flow_errors++;
                        $display("ERR %0t: latency %0d cycles, expected %0d", $time,
                                 ($time - t0) / PERIOD, LATENCY);
                    end
                end
            end
        end
        out_count++;
    endtask

    // Outputs first, so a window accepted on this edge cannot cover an output
    always @(posedge aclk) begin
        if (rst_n && m_valid && m_ready) begin
            record_output();
        end
        if (rst_n && s_valid && s_ready) begin
            if (beat_pos[in_count % beat_pos.size()] >= KERNEL_W - 1) begin
                windows_seen++;
                if (!stall_mode) begin
                    window_times.push_back($time);
                end
            end
            in_count++;
        end
    end

    // Back-pressure only in the second pass
    always @(posedge aclk) begin
        if (stall_mode) begin
            m_ready <= ($urandom % 4) != 0;
        end else begin
            m_ready <= 1'b1;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = 2 * (beat_pixel.size() + exp_data.size()) * 8 * PERIOD + RST_CYCLES * PERIOD;
        #(limit);
        $display("Timed out with %0d of %0d outputs received", out_count, 2 * exp_data.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        aclk         = 1'b0;
        rst_n        = 1'b0;
        s_valid      = 1'b0;
        s_pixel      = '0;
        s_weights    = '0;
        s_bias       = '0;
        s_last       = 1'b0;
        s_relu       = 1'b0;
        m_ready      = 1'b1;
        stall_mode   = 1'b0;
        data_errors  = 0;
        last_errors  = 0;
        flow_errors  = 0;
        in_count     = 0;
        out_count    = 0;
        windows_seen = 0;
        void'($urandom(32'h4782_9484));
        load_patterns();
        loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;

        // Empty slice must take a beat in the first cycle out of reset
        @(posedge aclk);
        if (s_ready !== 1'b1) begin
            flow_errors++;
            $display("Input not ready in the first cycle after reset at %0t", $time);
        end

        drive_pass(1'b0);
        wait_outputs(exp_data.size());
        stall_mode <= 1'b1;
        drive_pass(1'b1);
        wait_outputs(2 * exp_data.size());
        stall_mode <= 1'b0;
        // Room for any stray output to show up
        repeat (20) @(posedge aclk);

        $display("Errors: data %0d, last %0d, flow %0d", data_errors, last_errors, flow_errors);
        if (data_errors + last_errors + flow_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/conv_patterns.txt
# row: relu bias w0 w1 w2 count, then count pixels, all signed decimal
# exp: expected output and last flag, one line per full window of the row above
# Short row, no window
row 0 5 1 2 3 2 10 20
row 0 0 1 2 3 5 1 2 3 4 5
exp 14 0
exp 20 0
exp 26 1
# Negative results pass through
row 0 -10 2 -1 3 6 4 -3 7 0 -8 5
exp 22 0
exp -23 0
exp -20 0
exp 13 1
# Same row clamped
row 1 -10 2 -1 3 6 4 -3 7 0 -8 5
exp 22 0
exp 0 0
exp 0 0
exp 13 1
# Extremes, one window each
row 0 127 -128 -128 -128 3 -128 -128 -128
exp 49279 1
row 0 -128 127 127 127 3 -128 -128 -128
exp -48896 1
row 1 3 1 1 1 4 5 -20 6 -1
exp 0 0
exp 0 1
row 0 0 1 1 1 1 9
row 0 7 -3 5 1 8 10 -10 20 -20 30 -30 40 -40
exp -53 0
exp 117 0
exp -123 0
exp 187 0
exp -193 0
exp 257 1
row 1 -1 0 0 1 4 -5 6 -7 8
exp 0 0
exp 7 1

//--- list.f
hdl/conv_cfg_pkg.sv
hdl/conv_types_pkg.sv
hdl/conv_stream_if.sv
hdl/axis_reg_slice.sv
hdl/step_buffer.sv
hdl/mac_lane.sv
hdl/conv_unit.sv
hdl/conv_top.sv
bench/conv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= conv_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
